//--- Makefile
TOP = spiMasterTb

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f vlog.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

//--- logic/spiMaster.sv
`timescale 1ns/1ps

module spiMaster import spiPkg::*;
#(
  parameter int BaudWidth  = 8,
  parameter int TimerWidth = 16
)
(
  input  logic                AClkH,
  input  logic                AResetB,
  input  logic [1:0]          AAddr,
  input  logic [BusWidth-1:0] AMosi,
  input  logic [1:0]          AWrEn,
  input  logic [1:0]          ARdEn,
  output logic [BusWidth-1:0] AMiso,
  output logic                ASpiSck,
  input  logic                ASpiMiso,
  output logic                ASpiMosi,
  input  logic                ASpiGpioI,
  output logic [1:0]          ASpiGpioO,
  output logic [3:0]          ASpiOutEn
);

  // ************************************************************
  // Internal connections
  // ************************************************************
  logic                  busy;
  logic                  timerNZ;
  logic [ByteWidth-1:0]  rxByte;
  logic [ByteWidth-1:0]  txByte;
  logic                  wrData;
  logic                  msbLsb;
  logic [1:0]            mode;
  logic [BaudWidth-1:0]  baud;
  logic [TimerWidth-1:0] presCfg;
  logic [TimerWidth-1:0] tOutCfg;
  logic                  restart;

  // Host registers
  spiRegs #(
    .BaudWidth  (BaudWidth),
    .TimerWidth (TimerWidth)
  ) u_spiRegs (
    .AClkH     (AClkH),
    .AResetB   (AResetB),
    .AAddr     (AAddr),
    .AMosi     (AMosi),
    .AWrEn     (AWrEn),
    .ARdEn     (ARdEn),
    .AMiso     (AMiso),
    .ASpiGpioI (ASpiGpioI),
    .ASpiGpioO (ASpiGpioO),
    .ASpiOutEn (ASpiOutEn),
    .busy      (busy),
    .timerNZ   (timerNZ),
    .rxByte    (rxByte),
    .msbLsb    (msbLsb),
    .mode      (mode),
    .baud      (baud),
    .wrData    (wrData),
    .txByte    (txByte),
    .presCfg   (presCfg),
    .tOutCfg   (tOutCfg),
    .restart   (restart)
  );

  // Frame engine
  spiShifter #(
    .BaudWidth (BaudWidth)
  ) u_spiShifter (
    .AClkH    (AClkH),
    .AResetB  (AResetB),
    .wrData   (wrData),
    .txByte   (txByte),
    .msbLsb   (msbLsb),
    .mode     (mode),
    .baud     (baud),
    .ASpiMiso (ASpiMiso),
    .busy     (busy),
    .rxByte   (rxByte),
    .ASpiSck  (ASpiSck),
    .ASpiMosi (ASpiMosi)
  );

  // Timeout
  spiTimer #(
    .TimerWidth (TimerWidth)
  ) u_spiTimer (
    .AClkH   (AClkH),
    .AResetB (AResetB),
    .restart (restart),
    .presCfg (presCfg),
    .tOutCfg (tOutCfg),
    .timerNZ (timerNZ)
  );

endmodule

//--- logic/spiPkg.sv
package spiPkg;

  // ************************************************************
  // Register map
  // ************************************************************

  // Byte registers
  localparam logic [1:0] AbCtrl = 2'd0;
  localparam logic [1:0] AbBaud = 2'd1;
  localparam logic [1:0] AbData = 2'd2;
  localparam logic [1:0] AbGpio = 2'd3;

  // Word registers, separate from the bytes at the same address
  localparam logic [1:0] AwPres = 2'd2;
  localparam logic [1:0] AwTOut = 2'd3;

  // Access codes on AWrEn / ARdEn, 00 is idle and 10 never occurs
  localparam logic [1:0] AccByte = 2'b01;
  localparam logic [1:0] AccWord = 2'b11;

  localparam int BusWidth  = 16;
  localparam int ByteWidth = 8;

  // ************************************************************
  // Control byte fields
  // ************************************************************
  localparam int CtrlWrRd    = 7;
  localparam int CtrlMsbLsb  = 6;
  localparam int CtrlModeHi  = 5;
  localparam int CtrlModeLo  = 4;
  localparam int CtrlOutEnHi = 3;
  localparam int CtrlOutEnLo = 0;

  // Status bits replace WrRd and MsbLsb on read
  localparam int CtrlBusy    = 7;
  localparam int CtrlTimerNZ = 6;

  // 16 half-bits per 8-bit frame
  localparam logic [3:0] HalfBitCount = 4'd15;

endpackage

//--- logic/spiRegs.sv
`timescale 1ns/1ps

module spiRegs import spiPkg::*;
#(
  parameter int BaudWidth  = 8,
  parameter int TimerWidth = 16
)
(
  input  logic                  AClkH,
  input  logic                  AResetB,
  input  logic [1:0]            AAddr,
  input  logic [BusWidth-1:0]   AMosi,
  input  logic [1:0]            AWrEn,
  input  logic [1:0]            ARdEn,
  output logic [BusWidth-1:0]   AMiso,
  input  logic                  ASpiGpioI,
  output logic [1:0]            ASpiGpioO,
  output logic [3:0]            ASpiOutEn,
  input  logic                  busy,
  input  logic                  timerNZ,
  input  logic [ByteWidth-1:0]  rxByte,
  output logic                  msbLsb,
  output logic [1:0]            mode,
  output logic [BaudWidth-1:0]  baud,
  output logic                  wrData,
  output logic [ByteWidth-1:0]  txByte,
  output logic [TimerWidth-1:0] presCfg,
  output logic [TimerWidth-1:0] tOutCfg,
  output logic                  restart
);

  logic                  wrByte;
  logic                  rdByte;
  logic                  wrWord;
  logic                  rdWord;
  logic                  wrRd;
  logic [3:0]            outEn;
  logic [2:0]            gpioSync;
  logic [ByteWidth-1:0]  ctrlRd;
  logic [ByteWidth-1:0]  baudRd;
  logic [ByteWidth-1:0]  gpioRd;
  logic [ByteWidth-1:0]  byteRd;
  logic [TimerWidth-1:0] wordRd;

  // Access decode
  assign wrByte = (AWrEn == AccByte);
  assign rdByte = (ARdEn == AccByte);
  assign wrWord = (AWrEn == AccWord);
  assign rdWord = (ARdEn == AccWord);

  // ************************************************************
  // Register writes
  // ************************************************************
  always_ff @(posedge AClkH or negedge AResetB)
  begin
    if (!AResetB)
    begin
      wrRd      <= 1'b0;
      msbLsb    <= 1'b0;
      mode      <= '0;
      outEn     <= '0;
      baud      <= '0;
      ASpiGpioO <= '0;
      presCfg   <= '0;
      tOutCfg   <= '0;
    end
    else
    begin
      if (wrByte && (AAddr == AbCtrl))
      begin
        wrRd   <= AMosi[CtrlWrRd];
        msbLsb <= AMosi[CtrlMsbLsb];
        mode   <= AMosi[CtrlModeHi:CtrlModeLo];
        outEn  <= AMosi[CtrlOutEnHi:CtrlOutEnLo];
      end
      if (wrByte && (AAddr == AbBaud))
        baud <= AMosi[BaudWidth-1:0];
      if (wrByte && (AAddr == AbGpio))
        ASpiGpioO <= AMosi[1:0];
      if (wrWord && (AAddr == AwPres))
        presCfg <= AMosi[TimerWidth-1:0];
      if (wrWord && (AAddr == AwTOut))
        tOutCfg <= AMosi[TimerWidth-1:0];
    end
  end

  // GPIO input, three flops deep
  always_ff @(posedge AClkH or negedge AResetB)
  begin
    if (!AResetB)
      gpioSync <= '0;
    else
      gpioSync <= {gpioSync[1:0], ASpiGpioI};
  end

  // Data write kicks off a frame
  assign wrData  = wrByte && (AAddr == AbData);
  assign txByte  = AMosi[ByteWidth-1:0];
  assign restart = rdWord && (AAddr == AwTOut);

  // ************************************************************
  // Read data
  // ************************************************************
  always_comb
  begin
    ctrlRd                          = '0;
    ctrlRd[CtrlBusy]                = busy;
    ctrlRd[CtrlTimerNZ]             = timerNZ;
    ctrlRd[CtrlModeHi:CtrlModeLo]   = mode;
    ctrlRd[CtrlOutEnHi:CtrlOutEnLo] = outEn;
  end

  assign baudRd = ByteWidth'(baud);
  // Synchronized input sits at bit 4
  assign gpioRd = {3'b000, gpioSync[2], 2'b00, ASpiGpioO};

  assign byteRd = ({ByteWidth{rdByte && (AAddr == AbCtrl)}} & ctrlRd) |
                  ({ByteWidth{rdByte && (AAddr == AbBaud)}} & baudRd) |
                  ({ByteWidth{rdByte && (AAddr == AbData)}} & rxByte) |
                  ({ByteWidth{rdByte && (AAddr == AbGpio)}} & gpioRd);

  assign wordRd = ({TimerWidth{rdWord && (AAddr == AwPres)}} & presCfg) |
                  ({TimerWidth{rdWord && (AAddr == AwTOut)}} & tOutCfg);

  assign AMiso = BusWidth'(byteRd) | BusWidth'(wordRd);

  // Mosi pin enabled only while a write frame is on the wire
  assign ASpiOutEn = {outEn[3], outEn[2] & busy & wrRd, outEn[1:0]};

  illegalAccess: assert property (@(posedge AClkH) disable iff (!AResetB)
    (AWrEn != 2'b10) && (ARdEn != 2'b10));

endmodule

//--- logic/spiShifter.sv
`timescale 1ns/1ps

module spiShifter import spiPkg::*;
#(
  parameter int BaudWidth = 8
)
(
  input  logic                 AClkH,
  input  logic                 AResetB,
  input  logic                 wrData,
  input  logic [ByteWidth-1:0] txByte,
  input  logic                 msbLsb,
  input  logic [1:0]           mode,
  input  logic [BaudWidth-1:0] baud,
  input  logic                 ASpiMiso,
  output logic                 busy,
  output logic [ByteWidth-1:0] rxByte,
  output logic                 ASpiSck,
  output logic                 ASpiMosi
);

  logic [3:0]           halfCnt;
  logic [3:0]           halfCntNext;
  logic [BaudWidth-1:0] baudDiv;
  logic [BaudWidth-1:0] baudDivNext;
  logic                 sck;
  logic                 sckNext;
  logic                 misoQ;
  logic [ByteWidth-1:0] txLoad;
  logic [ByteWidth-1:0] txShift;
  logic [ByteWidth-1:0] txShiftNext;
  logic [ByteWidth-1:0] rxShift;
  logic [ByteWidth-1:0] rxShiftNext;
  logic                 divNZ;
  logic                 cntNZ;
  logic                 active;
  logic                 halfEnd;
  logic                 shiftEn;
  logic                 sampleEn;

  assign divNZ  = |baudDiv;
  assign cntNZ  = |halfCnt;
  assign active = divNZ | cntNZ;

  // Odd half-bit ends sample and even ones shift
  assign halfEnd  = active & ~divNZ;
  assign shiftEn  = halfEnd & ~halfCnt[0];
  assign sampleEn = halfEnd & halfCnt[0];

  // LSB-first frames are sent from a reversed copy
  always_comb
  begin
    for (int i = 0; i < ByteWidth; i++)
      txLoad[i] = msbLsb ? txByte[i] : txByte[ByteWidth-1-i];
  end

  // ************************************************************
  // Divider, half-bit counter and clock
  // ************************************************************
  always_comb
  begin
    if (wrData)
      baudDivNext = baud;
    else if (divNZ)
      baudDivNext = baudDiv - 1'b1;
    else if (cntNZ)
      baudDivNext = baud;
    else
      baudDivNext = '0;

    if (wrData)
      halfCntNext = HalfBitCount;
    else
      halfCntNext = halfCnt - {3'b000, ~divNZ & cntNZ};

    // Start level Mode1^Mode0 and idle level Mode1
    if (wrData)
      sckNext = mode[1] ^ mode[0];
    else if (active)
      sckNext = sck ^ ~divNZ;
    else
      sckNext = mode[1];
  end

  // ************************************************************
  // Shift registers
  // ************************************************************
  always_comb
  begin
    if (wrData)
      txShiftNext = txLoad;
    else if (shiftEn)
      txShiftNext = {txShift[ByteWidth-2:0], 1'b0};
    else
      txShiftNext = txShift;

    if (!sampleEn)
      rxShiftNext = rxShift;
    else if (msbLsb)
      rxShiftNext = {rxShift[ByteWidth-2:0], misoQ};
    else
      rxShiftNext = {misoQ, rxShift[ByteWidth-1:1]};
  end

  always_ff @(posedge AClkH or negedge AResetB)
  begin
    if (!AResetB)
    begin
      halfCnt <= '0;
      baudDiv <= '0;
      busy    <= 1'b0;
      sck     <= 1'b0;
      misoQ   <= 1'b0;
      txShift <= '0;
      rxShift <= '0;
    end
    else
    begin
      halfCnt <= halfCntNext;
      baudDiv <= baudDivNext;
      // Set by a data write and cleared once the counters have run out
      if (wrData)
        busy <= 1'b1;
      else if (!active)
        busy <= 1'b0;
      sck     <= sckNext;
      misoQ   <= ASpiMiso;
      txShift <= txShiftNext;
      rxShift <= rxShiftNext;
    end
  end

  assign rxByte   = rxShift;
  assign ASpiSck  = sck;
  assign ASpiMosi = txShift[ByteWidth-1];

  idleCounter: assert property (@(posedge AClkH) disable iff (!AResetB)
    !busy |-> (halfCnt == '0));

endmodule

//--- logic/spiTimer.sv
`timescale 1ns/1ps

module spiTimer
#(
  parameter int TimerWidth = 16
)
(
  input  logic                  AClkH,
  input  logic                  AResetB,
  input  logic                  restart,
  input  logic [TimerWidth-1:0] presCfg,
  input  logic [TimerWidth-1:0] tOutCfg,
  output logic                  timerNZ
);

  logic [TimerWidth-1:0] pres;
  logic [TimerWidth-1:0] presNext;
  logic [TimerWidth-1:0] tOut;
  logic [TimerWidth-1:0] tOutNext;
  logic                  presNZ;
  logic                  tOutNZ;
  logic                  running;

  assign presNZ  = |pres;
  assign tOutNZ  = |tOut;
  assign running = presNZ | tOutNZ;

  // Prescaler reloads on each wrap while the timeout is still counting
  always_comb
  begin
    if (restart)
      presNext = presCfg;
    else if (presNZ)
      presNext = pres - 1'b1;
    else if (running)
      presNext = presCfg;
    else
      presNext = '0;

    if (restart)
      tOutNext = tOutCfg;
    else
      tOutNext = tOut - {{(TimerWidth-1){1'b0}}, tOutNZ & ~presNZ};
  end

  always_ff @(posedge AClkH or negedge AResetB)
  begin
    if (!AResetB)
    begin
      pres    <= '0;
      tOut    <= '0;
      timerNZ <= 1'b0;
    end
    else
    begin
      pres    <= presNext;
      tOut    <= tOutNext;
      timerNZ <= (|presNext) | (|tOutNext);
    end
  end

  // Only a restart can start the timer
  noSpuriousStart: assert property (@(posedge AClkH) disable iff (!AResetB)
    $rose(timerNZ) |-> $past(restart));

endmodule

//--- verif/spiTbTasks.svh
`ifndef spiTbTasksSvh
`define spiTbTasksSvh

  // Host write taking effect on the second edge
  task automatic busWrite(input logic [1:0] acc, input logic [1:0] addr,
                          input logic [BusWidth-1:0] data);
    @(posedge AClkH);
    #1;
    AWrEn = acc;
    AAddr = addr;
    AMosi = data;
    @(posedge AClkH);
    #1;
    AWrEn = '0;
  endtask

  // Read data settles well before the falling edge
  task automatic busRead(input logic [1:0] acc, input logic [1:0] addr,
                         output logic [BusWidth-1:0] data);
    @(posedge AClkH);
    #1;
    ARdEn = acc;
    AAddr = addr;
    @(negedge AClkH);
    data = AMiso;
    @(posedge AClkH);
    #1;
    ARdEn = '0;
  endtask

  // ************************************************************
  // Loopback over all modes and both bit orders
  // ************************************************************
  task automatic testLoopback();
    logic [BusWidth-1:0] rd;
    logic [7:0]          ctrl;
    logic [7:0]          tx;
    logic [7:0]          baudVal;
    int                  polls;
    for (int m = 0; m < 4; m++)
    begin
      for (int o = 0; o < 2; o++)
      begin
        baudVal = 8'd1 + 8'({$random(seed)} % 6);
        tx      = 8'($random(seed));
        ctrl    = {1'(m ^ o), 1'(o), 2'(m), 4'($random(seed))};
        // Every pairing of WrRd and OutEn2 comes up
        ctrl[2] = (o == 0);
        busWrite(AccByte, AbBaud, {8'h00, baudVal});
        busWrite(AccByte, AbCtrl, {8'h00, ctrl});
        busWrite(AccByte, AbData, {8'h00, tx});
        busRead(AccByte, AbCtrl, rd);
        compare("busy after data write", 16'(rd[CtrlBusy]), 16'(1'b1));
        compare("first Mosi bit", 16'(ASpiMosi),
                16'(ctrl[CtrlMsbLsb] ? tx[7] : tx[0]));
        compare("output enables in frame", 16'(ASpiOutEn), 16'(expOutEn(ctrl, 1'b1)));
        polls = 0;
        while (rd[CtrlBusy] && polls < 200)
        begin
          busRead(AccByte, AbCtrl, rd);
          polls++;
        end
        if (rd[CtrlBusy])
        begin
          errors++;
          $display("Busy never fell during the loopback frame in mode %0d", m);
        end
        busRead(AccByte, AbData, rd);
        compare("loopback byte", rd, {8'h00, expLoopback(tx, ctrl[CtrlMsbLsb])});
        compare("Sck idle level", 16'(ASpiSck), 16'(ctrl[CtrlModeHi]));
        compare("output enables after frame", 16'(ASpiOutEn), 16'(expOutEn(ctrl, 1'b0)));
      end
    end
  endtask

  // ************************************************************
  // Timeout counter window
  // ************************************************************
  task automatic testTimer();
    logic [BusWidth-1:0] rd;
    int                  pres;
    int                  tOut;
    int                  restartCycle;
    int                  elapsed;
    int                  expNZ;
    for (int run = 0; run < 4; run++)
    begin
      pres = 1 + {$random(seed)} % 5;
      tOut = 2 + {$random(seed)} % 8;
      busWrite(AccWord, AwPres, 16'(pres));
      busWrite(AccWord, AwTOut, 16'(tOut));
      busRead(AccWord, AwPres, rd);
      compare("prescaler word", rd, 16'(pres));
      // Restart lands on the edge this read returns after
      busRead(AccWord, AwTOut, rd);
      restartCycle = cycleCnt;
      compare("timeout word", rd, 16'(tOut));
      elapsed = 0;
      while (elapsed < (tOut + 1) * (pres + 1) + 12)
      begin
        busRead(AccByte, AbCtrl, rd);
        elapsed = cycleCnt - 1 - restartCycle;
        expNZ   = expTimerNZ(elapsed, pres, tOut);
        if (expNZ >= 0)
          compare("timer nonzero flag", 16'(rd[CtrlTimerNZ]), 16'(expNZ[0]));
      end
    end
  endtask

`endif

//--- verif/spiMasterTb.sv
`timescale 1ns/1ps

module spiMasterTb import spiPkg::*;
();

  localparam int BaudWidth  = 8;
  localparam int TimerWidth = 16;
  // Eight frames of at most 112 cycles plus polling and four short timer runs
  // stay below 3000 cycles, so this limit leaves a wide margin
  localparam int TimeoutCycles = 20000;

  logic                AClkH;
  logic                AResetB;
  logic [1:0]          AAddr;
  logic [BusWidth-1:0] AMosi;
  logic [1:0]          AWrEn;
  logic [1:0]          ARdEn;
  logic [BusWidth-1:0] AMiso;
  logic                ASpiSck;
  logic                ASpiMosi;
  logic                ASpiGpioI;
  logic [1:0]          ASpiGpioO;
  logic [3:0]          ASpiOutEn;
  int                  cycleCnt = 0;
  int                  errors;
  int                  checks;
  integer              seed;

  // Miso looped back from Mosi
  spiMaster #(
    .BaudWidth  (BaudWidth),
    .TimerWidth (TimerWidth)
  ) u_spiMaster (
    .AClkH     (AClkH),
    .AResetB   (AResetB),
    .AAddr     (AAddr),
    .AMosi     (AMosi),
    .AWrEn     (AWrEn),
    .ARdEn     (ARdEn),
    .AMiso     (AMiso),
    .ASpiSck   (ASpiSck),
    .ASpiMiso  (ASpiMosi),
    .ASpiMosi  (ASpiMosi),
    .ASpiGpioI (ASpiGpioI),
    .ASpiGpioO (ASpiGpioO),
    .ASpiOutEn (ASpiOutEn)
  );

  initial
  begin
    AClkH = 1'b0;
    forever #5 AClkH = ~AClkH;
  end

  always @(posedge AClkH)
    cycleCnt <= cycleCnt + 1;

  initial
  begin
    wait (cycleCnt >= TimeoutCycles);
    $display("Timeout: the tests were still running after %0d cycles", TimeoutCycles);
    $display("Regression failed");
    $finish;
  end

  // ************************************************************
  // Reference model
  // ************************************************************
  function automatic logic [7:0] expCtrlRead(input logic [7:0] ctrl, input logic busyBit,
                                             input logic nzBit);
    logic [7:0] r;
    r              = ctrl;
    r[CtrlBusy]    = busyBit;
    r[CtrlTimerNZ] = nzBit;
    return r;
  endfunction

  // OutEn2 only while a write frame runs
  function automatic logic [3:0] expOutEn(input logic [7:0] ctrl, input logic busyBit);
    return {ctrl[3], ctrl[2] & busyBit & ctrl[CtrlWrRd], ctrl[1:0]};
  endfunction

  function automatic logic [7:0] expGpioRead(input logic [1:0] gpioOut, input logic gpioIn);
    return {3'b000, gpioIn, 2'b00, gpioOut};
  endfunction

  // Bits go out and come back in the same order
  function automatic logic [7:0] expLoopback(input logic [7:0] tx, input logic msbFirst);
    logic [7:0] rx;
    logic       wireBit;
    rx = '0;
    for (int i = 0; i < 8; i++)
    begin
      wireBit = msbFirst ? tx[7-i] : tx[i];
      rx      = msbFirst ? {rx[6:0], wireBit} : {wireBit, rx[7:1]};
    end
    return rx;
  endfunction

  // -1 inside the window where either level is allowed
  function automatic int expTimerNZ(input int elapsed, input int pres, input int tOut);
    if (elapsed < tOut * (pres + 1))
      return 1;
    if (elapsed >= (tOut + 1) * (pres + 1) + 2)
      return 0;
    return -1;
  endfunction

  task automatic compare(input string what, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  `include "spiTbTasks.svh"

  task automatic testReadback();
    logic [BusWidth-1:0] rd;
    logic [7:0]          val;
    for (int i = 0; i < 8; i++)
    begin
      val = 8'($random(seed));
      busWrite(AccByte, AbBaud, {8'h00, val});
      busRead(AccByte, AbBaud, rd);
      compare("baud readback", rd, {8'h00, val});
      val = 8'($random(seed));
      busWrite(AccByte, AbGpio, {8'h00, val});
      busRead(AccByte, AbGpio, rd);
      compare("GPIO readback", rd, {8'h00, expGpioRead(val[1:0], 1'b0)});
      compare("GPIO output pins", 16'(ASpiGpioO), 16'(val[1:0]));
      val = 8'($random(seed));
      busWrite(AccByte, AbCtrl, {8'h00, val});
      busRead(AccByte, AbCtrl, rd);
      compare("control readback", rd, {8'h00, expCtrlRead(val, 1'b0, 1'b0)});
      compare("output enables when idle", 16'(ASpiOutEn), 16'(expOutEn(val, 1'b0)));
    end
  endtask

  task automatic testGpio();
    logic [BusWidth-1:0] rd;
    logic                gpioIn;
    int                  startCycle;
    int                  lat;
    gpioIn = 1'b0;
    busWrite(AccByte, AbGpio, 16'h0002);
    compare("GPIO output pins", 16'(ASpiGpioO), 16'h0002);
    for (int i = 0; i < 4; i++)
    begin
      @(posedge AClkH);
      #1;
      gpioIn     = ~gpioIn;
      ASpiGpioI  = gpioIn;
      startCycle = cycleCnt;
      lat        = 0;
      rd         = '0;
      rd[4]      = ~gpioIn;
      while (rd[4] !== gpioIn && lat <= 4)
      begin
        busRead(AccByte, AbGpio, rd);
        lat = cycleCnt - 1 - startCycle;
      end
      compare("GPIO input byte", rd, {8'h00, expGpioRead(2'b10, gpioIn)});
      if (lat > 4)
      begin
        errors++;
        $display("GPIO input change took %0d cycles to reach the read byte", lat);
      end
    end
  endtask

  // ************************************************************
  // Test sequence
  // ************************************************************
  initial
  begin
    AResetB   = 1'b0;
    AAddr     = '0;
    AMosi     = '0;
    AWrEn     = '0;
    ARdEn     = '0;
    ASpiGpioI = 1'b0;
    errors    = 0;
    checks    = 0;
    seed      = 32'he43f_361c;
    repeat (2) @(posedge AClkH);
    #1;
    AResetB = 1'b1;
    compare("output enables after reset", 16'(ASpiOutEn), 16'h0000);
    compare("GPIO outputs after reset", 16'(ASpiGpioO), 16'h0000);
    compare("read data when idle", AMiso, 16'h0000);
    testReadback();
    testLoopback();
    testTimer();
    testGpio();
    $display("Checks run %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+verif
logic/spiPkg.sv
logic/spiTimer.sv
logic/spiShifter.sv
logic/spiRegs.sv
logic/spiMaster.sv
verif/spiMasterTb.sv
